// File: project.f
+incdir+include
hw/nntp_scan_pkg.sv
hw/nntp_dfa.sv
hw/stream_context_mem.sv
hw/stream_enable_table.sv
hw/stream_regex_counter.sv
hw/nntp_scan_top.sv
sim/nntp_scan_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the nntp scanner testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module nntp_scan_tb \
  -f project.f \
  -o nntp_scan_sim

./obj_dir/nntp_scan_sim | tee sim.log

# Result is taken from the log
if grep -q "TEST PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: include/nntp_tb_checks.svh
`ifndef NNTP_TB_CHECKS_SVH
`define NNTP_TB_CHECKS_SVH

// Included inside the testbench module
// The module must declare clk, pkt (pkt_in_t) and cfg (cfg_wr_t) first

// One stimulus table row
typedef struct
{
  string                             name;
  logic [7:0]                        stream;
  string                             text;
  bit                                cfg_we;
  bit                                cfg_en;
  logic [nntp_scan_pkg::COUNT_W-1:0] exp_count;
  logic                              exp_fired;
} stim_entry_t;

// Running check tallies
int pass_cnt = 0;
int fail_cnt = 0;

task automatic check_count(input string name,
                           input logic [nntp_scan_pkg::COUNT_W-1:0] exp,
                           input logic [nntp_scan_pkg::COUNT_W-1:0] act);
  if (act !== exp)
  begin
    $display("ERR  %s count exp=%0d act=%0d", name, exp, act);
    fail_cnt++;
  end
  else
  begin
    $display("OK   %s count=%0d", name, act);
    pass_cnt++;
  end
endtask

task automatic check_fired(input string name, input logic exp, input logic act);
  if (act !== exp)
  begin
    $display("ERR  %s fired exp=%0b act=%0b", name, exp, act);
    fail_cnt++;
  end
  else
  begin
    $display("OK   %s fired=%0b", name, act);
    pass_cnt++;
  end
endtask

// Enable write, kept outside any packet
task automatic cfg_write(input logic [7:0] stream, input logic en);
  @(negedge clk);
  cfg.we     = 1'b1;
  cfg.stream = stream;
  cfg.enable = en;
  @(negedge clk);
  cfg = '0;
endtask

// sop, 3 idle cycles, characters, 3 idle cycles, eop
task automatic drive_pkt(input logic [7:0] stream, input string text);
  int i;
  @(negedge clk);
  pkt           = '0;
  pkt.sop       = 1'b1;
  pkt.stream_id = stream;
  @(negedge clk);
  pkt.sop = 1'b0;
  repeat (3) @(negedge clk);
  for (i = 0; i < text.len(); i++)
  begin
    pkt.char_vld = 1'b1;
    pkt.char     = text[i];
    @(negedge clk);
  end
  pkt.char_vld = 1'b0;
  repeat (3) @(negedge clk);
  pkt.eop = 1'b1;
  @(negedge clk);
  pkt.eop = 1'b0;
endtask

`endif

// File: sim/nntp_scan_tb.sv
`timescale 1ns/10ps

module nntp_scan_tb;

  localparam int STREAM_ID_W = 6;
  localparam int N_STREAMS   = 2 ** STREAM_ID_W;
  localparam int CW          = nntp_scan_pkg::COUNT_W;
  localparam int N_DIRECTED  = 11;
  localparam int N_RANDOM    = 40;
  // Longest packet plus its enable write stays below 30 cycles
  localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 30 + 100;

  logic                   clk;
  logic                   rst_n;
  nntp_scan_pkg::pkt_in_t pkt;
  nntp_scan_pkg::cfg_wr_t cfg;
  logic [CW-1:0]          count;
  logic                   fired;

  `include "nntp_tb_checks.svh"

  // Directed rows come first and random rows follow
  stim_entry_t stim_q[$];

  // Reference model of the scanner
  nntp_scan_pkg::dfa_state_t model_state [N_STREAMS];
  bit                        model_en    [N_STREAMS];
  logic [CW-1:0]             model_count;

  integer seed;
  int     cycle_cnt;

  nntp_scan_top #(.STREAM_ID_W(STREAM_ID_W)) uut
  (
    .clk   (clk),
    .rst_n (rst_n),
    .pkt   (pkt),
    .cfg   (cfg),
    .count (count),
    .fired (fired)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Longest suffix of the seen text that is a prefix of "nntp"
  function automatic nntp_scan_pkg::dfa_state_t keyword_step(
    input nntp_scan_pkg::dfa_state_t cur, input logic [7:0] ch);
    string      kw;
    string      hist;
    string      cs;
    logic [7:0] lc;
    int         k;
    int         len;
    nntp_scan_pkg::dfa_state_t nxt;
    kw  = "nntp";
    lc  = (ch >= 8'h41 && ch <= 8'h5a) ? ch + 8'h20 : ch;
    cs  = " ";
    cs.putc(0, lc);
    // After a full hit no suffix is useful because p starts nothing
    k   = (cur == nntp_scan_pkg::S_HIT) ? 0 : int'(cur);
    hist = (k == 0) ? "" : kw.substr(0, k - 1);
    hist = {hist, cs};
    nxt = nntp_scan_pkg::S_IDLE;
    for (len = (hist.len() < 4) ? hist.len() : 4; len > 0; len--)
    begin
      if (nxt == nntp_scan_pkg::S_IDLE &&
          hist.substr(hist.len() - len, hist.len() - 1) == kw.substr(0, len - 1))
      begin
        case (len)
          1:       nxt = nntp_scan_pkg::S_N;
          2:       nxt = nntp_scan_pkg::S_NN;
          3:       nxt = nntp_scan_pkg::S_NNT;
          default: nxt = nntp_scan_pkg::S_HIT;
        endcase
      end
    end
    return nxt;
  endfunction

  // Runs one packet through the model and returns count and fired after eop
  task automatic model_packet(input logic [7:0] stream, input string text,
                              input bit cfg_we, input bit cfg_en,
                              output logic [CW-1:0] exp_count, output logic exp_fired);
    int sid;
    int i;
    bit hit;
    nntp_scan_pkg::dfa_state_t st;
    sid = int'(stream[STREAM_ID_W-1:0]);
    if (cfg_we)
    begin
      model_en[sid] = cfg_en;
    end
    st  = model_state[sid];
    hit = 1'b0;
    for (i = 0; i < text.len(); i++)
    begin
      st = keyword_step(st, text[i]);
      if (st == nntp_scan_pkg::S_HIT)
      begin
        hit = 1'b1;
      end
    end
    // Disabled streams keep their old context
    if (model_en[sid])
    begin
      model_state[sid] = st;
      if (hit)
      begin
        model_count = model_count + CW'(1);
      end
    end
    exp_count = model_count;
    exp_fired = model_en[sid] & hit;
  endtask

  task automatic add_entry(input string name, input logic [7:0] stream, input string text,
                           input bit cfg_we, input bit cfg_en,
                           input logic [CW-1:0] exp_count, input logic exp_fired);
    stim_entry_t e;
    e.name      = name;
    e.stream    = stream;
    e.text      = text;
    e.cfg_we    = cfg_we;
    e.cfg_en    = cfg_en;
    e.exp_count = exp_count;
    e.exp_fired = exp_fired;
    stim_q.push_back(e);
  endtask

  // Row with hand-written expectations that the reference model must agree with
  task automatic add_directed(input string name, input logic [7:0] stream, input string text,
                              input bit cfg_we, input bit cfg_en,
                              input logic [CW-1:0] exp_count, input logic exp_fired);
    logic [CW-1:0] c;
    logic          f;
    model_packet(stream, text, cfg_we, cfg_en, c, f);
    if (c !== exp_count || f !== exp_fired)
    begin
      $display("Reference model disagrees with the expected values of row %s", name);
      fail_cnt++;
    end
    add_entry(name, stream, text, cfg_we, cfg_en, exp_count, exp_fired);
  endtask

  task automatic build_table();
    string       letters;
    string       text;
    logic [31:0] rnd;
    logic [7:0]  stream;
    logic [CW-1:0] c;
    logic        f;
    bit          we;
    bit          en;
    int          len;
    int          j;
    int          k;
    letters = "ntpxNTPX";
    model_count = '0;
    for (k = 0; k < N_STREAMS; k++)
    begin
      model_state[k] = nntp_scan_pkg::S_IDLE;
      model_en[k]    = 1'b0;
    end
    add_directed("basic",        8'd1, "xxnntpyy",  1'b1, 1'b1, 16'd1, 1'b1);
    add_directed("mixed_case",   8'd2, "xNnTpx",    1'b1, 1'b1, 16'd2, 1'b1);
    add_directed("two_matches",  8'd2, "nntpxnntp", 1'b0, 1'b0, 16'd3, 1'b1);
    // Keyword split over two packets of one stream
    add_directed("split_a",      8'd3, "..nn",      1'b1, 1'b1, 16'd3, 1'b0);
    add_directed("split_b",      8'd3, "tp..",      1'b0, 1'b0, 16'd4, 1'b1);
    // Same split with another stream in between
    add_directed("ilv_a",        8'd4, "abnn",      1'b1, 1'b1, 16'd4, 1'b0);
    add_directed("ilv_other",    8'd5, "nnxt",      1'b1, 1'b1, 16'd4, 1'b0);
    add_directed("ilv_b",        8'd4, "tpab",      1'b0, 1'b0, 16'd5, 1'b1);
    // Ends in S_NNT but is never saved
    add_directed("disabled",     8'd6, "nntpnnt",   1'b1, 1'b0, 16'd5, 1'b0);
    add_directed("fresh_stream", 8'd7, "p.x",       1'b1, 1'b1, 16'd5, 1'b0);
    add_directed("enabled_late", 8'd6, "pxx",       1'b1, 1'b1, 16'd5, 1'b0);
    // Sixteen streams so contexts get reused often
    for (k = 0; k < N_RANDOM; k++)
    begin
      rnd    = $random(seed);
      stream = 8'(rnd[3:0]);
      we     = rnd[4];
      en     = (rnd[6:5] != 2'b00);
      len    = 1 + int'(rnd[11:8]) % 12;
      text   = "";
      for (j = 0; j < len; j++)
      begin
        rnd  = $random(seed);
        text = {text, letters.substr(int'(rnd[2:0]), int'(rnd[2:0]))};
      end
      model_packet(stream, text, we, en, c, f);
      add_entry($sformatf("rand_%0d", k), stream, text, we, en, c, f);
    end
  endtask

  initial
  begin
    seed  = 32'hf0cb;
    rst_n = 1'b0;
    pkt   = '0;
    cfg   = '0;
    build_table();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_count("reset", '0, count);
    check_fired("reset", 1'b0, fired);
    foreach (stim_q[i])
    begin
      if (stim_q[i].cfg_we)
      begin
        cfg_write(stim_q[i].stream, stim_q[i].cfg_en);
      end
      drive_pkt(stim_q[i].stream, stim_q[i].text);
      // Sampled one cycle after eop and before the next sop
      check_count(stim_q[i].name, stim_q[i].exp_count, count);
      check_fired(stim_q[i].name, stim_q[i].exp_fired, fired);
    end
    $display("Checks passed: %0d  failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: hw/nntp_scan_top.sv
`timescale 1ns/10ps

module nntp_scan_top
#(
  parameter int STREAM_ID_W = 6
)
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  nntp_scan_pkg::pkt_in_t            pkt,
  input  nntp_scan_pkg::cfg_wr_t            cfg,
  output logic [nntp_scan_pkg::COUNT_W-1:0] count,
  output logic                              fired
);

  // Enable bit of the open packet
  logic                      enable;

  // Context restore, one cycle after sop
  nntp_scan_pkg::dfa_state_t restore;
  logic                      restore_vld;

  // Context save at eop
  logic                      save_we;
  logic [STREAM_ID_W-1:0]    save_stream;
  nntp_scan_pkg::dfa_state_t save_state;

  stream_context_mem #(.STREAM_ID_W(STREAM_ID_W)) u_ctx_mem
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt         (pkt),
    .save_we     (save_we),
    .save_stream (save_stream),
    .save_state  (save_state),
    .restore     (restore),
    .restore_vld (restore_vld)
  );

  stream_enable_table #(.STREAM_ID_W(STREAM_ID_W)) u_enable_table
  (
    .clk    (clk),
    .rst_n  (rst_n),
    .cfg    (cfg),
    .pkt    (pkt),
    .enable (enable)
  );

  stream_regex_counter #(.STREAM_ID_W(STREAM_ID_W)) u_counter
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt         (pkt),
    .enable      (enable),
    .restore     (restore),
    .restore_vld (restore_vld),
    .save_we     (save_we),
    .save_stream (save_stream),
    .save_state  (save_state),
    .count       (count),
    .fired       (fired)
  );

endmodule

// File: hw/stream_regex_counter.sv
`timescale 1ns/10ps

module stream_regex_counter
#(
  parameter int STREAM_ID_W = 6
)
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  nntp_scan_pkg::pkt_in_t              pkt,
  input  logic                                enable,
  input  nntp_scan_pkg::dfa_state_t           restore,
  input  logic                                restore_vld,
  output logic                                save_we,
  output logic [STREAM_ID_W-1:0]              save_stream,
  output nntp_scan_pkg::dfa_state_t           save_state,
  output logic [nntp_scan_pkg::COUNT_W-1:0]   count,
  output logic                                fired
);

  // Automaton inputs, one register stage
  logic                      char_vld_r;
  logic [7:0]                char_r;
  logic                      restore_vld_r;
  nntp_scan_pkg::dfa_state_t restore_r;

  // Automaton outputs
  nntp_scan_pkg::dfa_state_t dfa_state;
  logic                      dfa_accept;
  nntp_scan_pkg::dfa_state_t state_r;
  logic                      accept_r;

  // High the cycle after the automaton stepped on a character
  logic upd_d;

  // Packet has matched so far
  logic spec_match;
  // Includes a hit still in the register stage at eop
  logic match_now;

  // Control side of the pipeline
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r    <= 1'b0;
      restore_vld_r <= 1'b0;
      upd_d         <= 1'b0;
      accept_r      <= 1'b0;
    end
    else
    begin
      char_vld_r    <= pkt.char_vld;
      restore_vld_r <= restore_vld;
      upd_d         <= char_vld_r;
      // Only a fresh step counts, so a stale S_HIT before a restore is ignored
      accept_r      <= dfa_accept & upd_d;
    end
  end

  // Payload side
  always_ff @(posedge clk)
  begin
    char_r    <= pkt.char;
    restore_r <= restore;
    state_r   <= dfa_state;
  end

  nntp_dfa u_dfa
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .char           (char_r),
    .char_vld       (char_vld_r),
    .state_load     (restore_r),
    .state_load_vld (restore_vld_r),
    .state          (dfa_state),
    .accept         (dfa_accept)
  );

  assign match_now = spec_match | accept_r;

  // Speculative flag and final count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      spec_match <= 1'b0;
      count      <= '0;
    end
    else
    begin
      // Disabled stream drops its result at eop
      if (pkt.eop && !enable)
      begin
        spec_match <= 1'b0;
      end
      // New packet starts clean
      else if (restore_vld)
      begin
        spec_match <= 1'b0;
      end
      else if (accept_r)
      begin
        spec_match <= 1'b1;
      end
      if (pkt.eop && enable)
      begin
        count <= count + {{(nntp_scan_pkg::COUNT_W-1){1'b0}}, match_now};
      end
    end
  end

  assign fired = spec_match;

  // State goes back to the context memory only for enabled streams
  assign save_we     = pkt.eop & enable;
  assign save_stream = pkt.stream_id[STREAM_ID_W-1:0];
  // S_HIT behaves as S_IDLE, stored that way so the next packet
  // of the stream does not see an old hit
  assign save_state  = (state_r == nntp_scan_pkg::S_HIT) ? nntp_scan_pkg::S_IDLE : state_r;

  // Host spacing rules, which the fixed latencies rely on
  a_sop_gap: assert property (@(posedge clk) disable iff (!rst_n)
    pkt.sop |-> (!pkt.char_vld) [*3]);

  a_eop_gap: assert property (@(posedge clk) disable iff (!rst_n)
    pkt.char_vld |-> (!pkt.eop) [*3]);

  a_eop_sop: assert property (@(posedge clk) disable iff (!rst_n)
    pkt.eop |-> !pkt.sop);

  a_stream_steady: assert property (@(posedge clk) disable iff (!rst_n)
    pkt.sop |=> $stable(save_stream) throughout pkt.eop [->1]);

endmodule

// File: hw/stream_enable_table.sv
`timescale 1ns/10ps

module stream_enable_table
#(
  parameter int STREAM_ID_W = 6
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  nntp_scan_pkg::cfg_wr_t cfg,
  input  nntp_scan_pkg::pkt_in_t pkt,
  output logic                   enable
);

  localparam int N_STREAMS = 2 ** STREAM_ID_W;

  // Host enable bit per stream, all off after reset
  logic [N_STREAMS-1:0] en_bits;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      en_bits <= '0;
    end
    else if (cfg.we)
    begin
      en_bits[cfg.stream[STREAM_ID_W-1:0]] <= cfg.enable;
    end
  end

  // Latched at sop, held for the whole packet
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      enable <= 1'b0;
    end
    else if (pkt.sop)
    begin
      enable <= en_bits[pkt.stream_id[STREAM_ID_W-1:0]];
    end
  end

  // Table must be quiet from sop through eop
  a_no_cfg_in_pkt: assert property (@(posedge clk) disable iff (!rst_n)
    pkt.sop |-> (!cfg.we) throughout pkt.eop [->1]);

endmodule

// File: hw/stream_context_mem.sv
`timescale 1ns/10ps

module stream_context_mem
#(
  parameter int STREAM_ID_W = 6
)
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  nntp_scan_pkg::pkt_in_t    pkt,
  input  logic                      save_we,
  input  logic [STREAM_ID_W-1:0]    save_stream,
  input  nntp_scan_pkg::dfa_state_t save_state,
  output nntp_scan_pkg::dfa_state_t restore,
  output logic                      restore_vld
);

  localparam int N_STREAMS = 2 ** STREAM_ID_W;

  // Saved automaton state per stream
  nntp_scan_pkg::dfa_state_t ctx_mem [N_STREAMS];

  // One bit per stream that has had a sop since reset
  logic [N_STREAMS-1:0] seen;

  logic [STREAM_ID_W-1:0] sid;

  assign sid = pkt.stream_id[STREAM_ID_W-1:0];

  // Seen bitmap
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen <= '0;
    end
    else if (pkt.sop)
    begin
      seen[sid] <= 1'b1;
    end
  end

  // Single write port
  // A new stream gets its slot cleared at sop, so a disabled first
  // packet still leaves a clean state behind for the next one
  always_ff @(posedge clk)
  begin
    if (pkt.sop && !seen[sid])
    begin
      ctx_mem[sid] <= nntp_scan_pkg::S_IDLE;
    end
    else if (save_we)
    begin
      ctx_mem[save_stream] <= save_state;
    end
  end

  // Restore value, valid one cycle after sop
  always_ff @(posedge clk)
  begin
    if (pkt.sop)
    begin
      restore <= seen[sid] ? ctx_mem[sid] : nntp_scan_pkg::S_IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      restore_vld <= 1'b0;
    end
    else
    begin
      restore_vld <= pkt.sop;
    end
  end

  // Save comes from the counter at eop, which never shares a cycle with sop
  a_save_not_sop: assert property (@(posedge clk) disable iff (!rst_n)
    save_we |-> !pkt.sop);

endmodule

// File: hw/nntp_dfa.sv
`timescale 1ns/10ps

module nntp_dfa
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [7:0]                char,
  input  logic                      char_vld,
  input  nntp_scan_pkg::dfa_state_t state_load,
  input  logic                      state_load_vld,
  output nntp_scan_pkg::dfa_state_t state,
  output logic                      accept
);

  // Character folded to lower case
  logic [7:0] char_lc;
  logic       is_n;
  logic       is_t;
  logic       is_p;

  // State reached by the current character
  nntp_scan_pkg::dfa_state_t step;

  // Upper case letters only, other bytes pass unchanged
  always_comb
  begin
    char_lc = char;
    if (char >= 8'h41 && char <= 8'h5a)
    begin
      char_lc = char | 8'h20;
    end
  end

  assign is_n = (char_lc == 8'h6e);
  assign is_t = (char_lc == 8'h74);
  assign is_p = (char_lc == 8'h70);

  // Transition function
  // Default is the mismatch path: an n restarts at S_N, anything else at S_IDLE
  always_comb
  begin
    step = is_n ? nntp_scan_pkg::S_N : nntp_scan_pkg::S_IDLE;
    case (state)
      nntp_scan_pkg::S_N:
      begin
        if (is_n)
        begin
          step = nntp_scan_pkg::S_NN;
        end
      end
      nntp_scan_pkg::S_NN:
      begin
        if (is_t)
        begin
          step = nntp_scan_pkg::S_NNT;
        end
        // "nnn" still ends in "nn"
        else if (is_n)
        begin
          step = nntp_scan_pkg::S_NN;
        end
      end
      nntp_scan_pkg::S_NNT:
      begin
        if (is_p)
        begin
          step = nntp_scan_pkg::S_HIT;
        end
      end
      // S_IDLE and S_HIT both take the mismatch path
      default:
      begin
      end
    endcase
  end

  // Load from the context memory wins over a character
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= nntp_scan_pkg::S_IDLE;
    end
    else if (state_load_vld)
    begin
      state <= state_load;
    end
    else if (char_vld)
    begin
      state <= step;
    end
  end

  assign accept = (state == nntp_scan_pkg::S_HIT);

  // Restore path and char path are separate pipelines
  // Host spacing keeps them apart
  a_load_char_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(state_load_vld && char_vld));

endmodule

// File: hw/nntp_scan_pkg.sv
package nntp_scan_pkg;

  // Width of the running match count
  localparam int COUNT_W = 16;

  // Progress through the keyword "nntp"
  // S_HIT means the last character completed the keyword
  typedef enum logic [2:0]
  {
    S_IDLE = 3'd0,
    S_N    = 3'd1,
    S_NN   = 3'd2,
    S_NNT  = 3'd3,
    S_HIT  = 3'd4
  } dfa_state_t;

  // One cycle of packet input from the host
  // sop and eop frame a packet of one stream
  // char is only meaningful while char_vld is high
  // Only the low STREAM_ID_W bits of stream_id select a stream
  typedef struct packed
  {
    logic       sop;
    logic       eop;
    logic       char_vld;
    logic [7:0] char;
    logic [7:0] stream_id;
  } pkt_in_t;

  // Host write into the per-stream enable table
  // Only legal between packets
  typedef struct packed
  {
    logic       we;
    logic [7:0] stream;
    logic       enable;
  } cfg_wr_t;

endpackage
